// File: design/asic_config.svh
/*
 * Build-time parameters for the memory bring-up top
 *   reset hold, SRAM size, self-test length and seed,
 *   out-of-range test base and the GPIO direction mask
 */
`ifndef ASIC_CONFIG_SVH
`define ASIC_CONFIG_SVH

// Cycles the system reset stays low once lock and external reset are good
`define ASIC_RST_HOLD 16

// SRAM word-address bits, 32-bit words
`define ASIC_SRAM_ABITS 8

// Words written and read back per self-test run
`define ASIC_TEST_WORDS 16

// XOR seed for the address pattern
`define ASIC_TEST_SEED 32'h5a5a_0f0f

// Byte base selected by DIP[3], beyond the SRAM window
`define ASIC_OUT_BASE 32'h0001_0000

// Set bits are output pads (LEDs on [11:4])
`define ASIC_GPIO_OUT_MASK 12'hff0

`endif

// File: design/asic_pkg.sv
/*
 * Shared types for the memory bring-up top
 *   AXI4 field widths and response codes
 *   GPIO pad vector
 *   self-test pattern kinds
 *   single-beat AXI4 request and response bundles
 */
package asic_pkg;

  typedef logic [31:0] axi_addr_t;
  typedef logic [31:0] axi_data_t;
  typedef logic [3:0]  axi_strb_t;
  typedef logic [1:0]  axi_resp_t;
  typedef logic [11:0] gpio_t;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

  // Data pattern selected by DIP[2:1]
  typedef enum logic [1:0] {
    ADDR_XOR = 2'd0,
    ZEROS    = 2'd1,
    ONES     = 2'd2,
    WALK_ONE = 2'd3
  } pattern_kind_t;

  // Master to slave
  typedef struct packed {
    logic      aw_valid;
    axi_addr_t aw_addr;
    logic      w_valid;
    axi_data_t w_data;
    axi_strb_t w_strb;
    logic      w_last;
    logic      b_ready;
    logic      ar_valid;
    axi_addr_t ar_addr;
    logic      r_ready;
  } axi4_req_t;

  // Slave to master
  typedef struct packed {
    logic      aw_ready;
    logic      w_ready;
    logic      b_valid;
    axi_resp_t b_resp;
    logic      ar_ready;
    logic      r_valid;
    axi_data_t r_data;
    axi_resp_t r_resp;
    logic      r_last;
  } axi4_rsp_t;

endpackage

// File: design/sys_reset_ctrl.sv
/*
 * System reset controller
 *   external reset and PLL lock sampled on the system clock,
 *   release delayed by a hold counter
 */
`timescale 1ns/100ps
`include "asic_config.svh"

module sys_reset_ctrl (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_pll_locked,
  output logic o_sys_rst_n
);

  localparam int CNT_W = $clog2(`ASIC_RST_HOLD + 1);

  logic [CNT_W-1:0] hold_cnt;
  logic             rst_cond;

  // Either source pulls the system into reset
  assign rst_cond = !i_rst_n || !i_pll_locked;

  always_ff @(posedge i_clk) begin
    if (rst_cond) begin
      hold_cnt    <= '0;
      o_sys_rst_n <= 1'b0;
    end else if (hold_cnt == CNT_W'(`ASIC_RST_HOLD - 1)) begin
      o_sys_rst_n <= 1'b1;
    end else begin
      hold_cnt <= hold_cnt + 1'b1;
    end
  end

  // Lock loss must reach the system reset on the very next edge
  a_lock_loss: assert property (
    @(posedge i_clk) !i_pll_locked |=> !o_sys_rst_n
  );

endmodule

// File: design/gpio_pad_bank.sv
/*
 * GPIO pad bank
 *   behavioural tristate drivers under a fixed direction mask,
 *   LEDs placed on the output pads,
 *   two-flop synchronizers on the DIP switch inputs
 */
`timescale 1ns/100ps
`include "asic_config.svh"

module gpio_pad_bank (
  input  logic          i_clk,
  input  logic          i_rst_n,
  inout  asic_pkg::gpio_t io_gpio,
  input  logic [7:0]    i_led,
  output logic [3:0]    o_dip
);

  localparam asic_pkg::gpio_t OUT_MASK = `ASIC_GPIO_OUT_MASK;

  asic_pkg::gpio_t pad_out;
  logic [3:0]      dip_meta;
  logic [3:0]      dip_sync;

  // LEDs sit above the four switch pads
  assign pad_out = {i_led, 4'b0000};

  genvar i;
  generate
    for (i = 0; i < 12; i++) begin : g_pad
      assign io_gpio[i] = OUT_MASK[i] ? pad_out[i] : 1'bz;
    end
  endgenerate

  // Switches are asynchronous to the system clock
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      dip_meta <= '0;
      dip_sync <= '0;
    end else begin
      dip_meta <= io_gpio[3:0];
      dip_sync <= dip_meta;
    end
  end

  assign o_dip = dip_sync;

endmodule

// File: design/mem_selftest.sv
/*
 * Memory self-test engine, single-beat AXI4 master
 *   start on a rising DIP[0], pattern from DIP[2:1], base from DIP[3]
 *   write phase, read-back phase, saturating error count
 *   busy/done/pass/fail and error count on the LEDs
 */
`timescale 1ns/100ps
`include "asic_config.svh"

module mem_selftest (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic [3:0]          i_dip,
  output logic [7:0]          o_led,
  output asic_pkg::axi4_req_t o_axi,
  input  asic_pkg::axi4_rsp_t i_axi
);

  localparam int IDX_W = $clog2(`ASIC_TEST_WORDS);

  typedef enum logic [2:0] {
    IDLE,
    WR_REQ,
    WR_RSP,
    RD_REQ,
    RD_RSP,
    DONE
  } state_t;

  state_t                  state;
  asic_pkg::pattern_kind_t kind;
  asic_pkg::axi_addr_t     base;
  asic_pkg::axi_addr_t     cur_addr;
  asic_pkg::axi_data_t     cur_data;
  logic [IDX_W-1:0]        idx;
  logic [3:0]              err_cnt;
  logic                    dip0_q;
  logic                    start;
  logic                    last_word;
  logic                    wr_bad;
  logic                    rd_bad;
  logic                    done;

  function automatic asic_pkg::axi_data_t pattern_word(
    asic_pkg::pattern_kind_t k,
    asic_pkg::axi_addr_t     addr,
    logic [IDX_W-1:0]        i
  );
    asic_pkg::axi_data_t w;
    case (k)
      asic_pkg::ADDR_XOR: w = asic_pkg::axi_data_t'(addr >> 2) ^ `ASIC_TEST_SEED;
      asic_pkg::ZEROS:    w = '0;
      asic_pkg::ONES:     w = '1;
      default:            w = asic_pkg::axi_data_t'(1) << 5'(i);
    endcase
    return w;
  endfunction

  // Start is honoured only between runs
  assign start = i_dip[0] && !dip0_q && (state == IDLE || state == DONE);

  assign cur_addr  = base + asic_pkg::axi_addr_t'({idx, 2'b00});
  assign cur_data  = pattern_word(kind, cur_addr, idx);
  assign last_word = (idx == IDX_W'(`ASIC_TEST_WORDS - 1));

  assign wr_bad = (i_axi.b_resp != asic_pkg::RESP_OKAY);
  assign rd_bad = (i_axi.r_resp != asic_pkg::RESP_OKAY) || (i_axi.r_data != cur_data);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state   <= IDLE;
      kind    <= asic_pkg::ADDR_XOR;
      base    <= '0;
      idx     <= '0;
      err_cnt <= '0;
      dip0_q  <= 1'b0;
    end else begin
      dip0_q <= i_dip[0];
      if (start) begin
        kind    <= asic_pkg::pattern_kind_t'(i_dip[2:1]);
        base    <= i_dip[3] ? `ASIC_OUT_BASE : '0;
        idx     <= '0;
        err_cnt <= '0;
        state   <= WR_REQ;
      end else begin
        case (state)
          WR_REQ: begin
            if (i_axi.aw_ready && i_axi.w_ready) begin
              state <= WR_RSP;
            end
          end
          WR_RSP: begin
            if (i_axi.b_valid) begin
              if (wr_bad && err_cnt != 4'hf) begin
                err_cnt <= err_cnt + 1'b1;
              end
              idx   <= last_word ? '0 : idx + 1'b1;
              state <= last_word ? RD_REQ : WR_REQ;
            end
          end
          RD_REQ: begin
            if (i_axi.ar_ready) begin
              state <= RD_RSP;
            end
          end
          RD_RSP: begin
            if (i_axi.r_valid) begin
              // One count per beat, bad response or bad data
              if (rd_bad && err_cnt != 4'hf) begin
                err_cnt <= err_cnt + 1'b1;
              end
              idx   <= last_word ? idx : idx + 1'b1;
              state <= last_word ? DONE : RD_REQ;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Bus outputs decode straight from the state, payload from the index
  always_comb begin
    o_axi          = '0;
    o_axi.aw_valid = (state == WR_REQ);
    o_axi.aw_addr  = cur_addr;
    o_axi.w_valid  = (state == WR_REQ);
    o_axi.w_data   = cur_data;
    o_axi.w_strb   = '1;
    o_axi.w_last   = 1'b1;
    o_axi.b_ready  = (state == WR_RSP);
    o_axi.ar_valid = (state == RD_REQ);
    o_axi.ar_addr  = cur_addr;
    o_axi.r_ready  = (state == RD_RSP);
  end

  assign done     = (state == DONE);
  assign o_led[0] = (state != IDLE) && !done;
  assign o_led[1] = done;
  assign o_led[2] = done && (err_cnt == 4'h0);
  assign o_led[3] = done && (err_cnt != 4'h0);
  assign o_led[7:4] = err_cnt;

  // No new write is issued while a B response is still owed
  a_no_aw_in_b: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
      !(o_axi.aw_valid && (o_axi.b_ready || i_axi.b_valid))
  );

endmodule

// File: design/axi4_sram.sv
/*
 * Single-beat AXI4 SRAM model
 *   write and read channels with one pending response each,
 *   byte strobes, SLVERR beyond the array, r_last always set
 */
`timescale 1ns/100ps
`include "asic_config.svh"

module axi4_sram (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  asic_pkg::axi4_req_t i_axi,
  output asic_pkg::axi4_rsp_t o_axi
);

  localparam int ABITS = `ASIC_SRAM_ABITS;
  localparam int DEPTH = 1 << ABITS;

  asic_pkg::axi_data_t mem [DEPTH];

  logic                b_pend;
  asic_pkg::axi_resp_t b_resp;
  logic                r_pend;
  asic_pkg::axi_resp_t r_resp;
  asic_pkg::axi_data_t r_data;

  logic             wr_fire;
  logic             rd_fire;
  logic             wr_hit;
  logic             rd_hit;
  logic [ABITS-1:0] wr_word;
  logic [ABITS-1:0] rd_word;

  // Address and data are taken together, only with no B owed
  assign wr_fire = i_axi.aw_valid && i_axi.w_valid && !b_pend;
  assign rd_fire = i_axi.ar_valid && !r_pend;

  // Anything above the word window decodes as a miss
  assign wr_hit  = (i_axi.aw_addr[31:ABITS+2] == '0);
  assign rd_hit  = (i_axi.ar_addr[31:ABITS+2] == '0);
  assign wr_word = i_axi.aw_addr[ABITS+1:2];
  assign rd_word = i_axi.ar_addr[ABITS+1:2];

  // Write response channel
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      b_pend <= 1'b0;
    end else if (wr_fire) begin
      b_pend <= 1'b1;
    end else if (i_axi.b_ready) begin
      b_pend <= 1'b0;
    end
  end

  // Read response channel
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_pend <= 1'b0;
    end else if (rd_fire) begin
      r_pend <= 1'b1;
    end else if (i_axi.r_ready) begin
      r_pend <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (wr_fire) begin
      b_resp <= wr_hit ? asic_pkg::RESP_OKAY : asic_pkg::RESP_SLVERR;
    end
    if (rd_fire) begin
      r_resp <= rd_hit ? asic_pkg::RESP_OKAY : asic_pkg::RESP_SLVERR;
      r_data <= rd_hit ? mem[rd_word] : '0;
    end
  end

  // Array write, per byte lane
  always_ff @(posedge i_clk) begin
    for (int b = 0; b < 4; b++) begin
      if (wr_fire && wr_hit && i_axi.w_strb[b]) begin
        mem[wr_word][8*b +: 8] <= i_axi.w_data[8*b +: 8];
      end
    end
  end

  always_comb begin
    o_axi          = '0;
    o_axi.aw_ready = !b_pend;
    o_axi.w_ready  = !b_pend;
    o_axi.b_valid  = b_pend;
    o_axi.b_resp   = b_resp;
    o_axi.ar_ready = !r_pend;
    o_axi.r_valid  = r_pend;
    o_axi.r_data   = r_data;
    o_axi.r_resp   = r_resp;
    o_axi.r_last   = 1'b1;
  end

  // Master must only send single-beat writes
  a_wlast: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) wr_fire |-> i_axi.w_last
  );

  // AW and W are raised and dropped as a pair
  a_aw_w_pair: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_axi.aw_valid == i_axi.w_valid
  );

endmodule

// File: design/asic_top.sv
/*
 * Board-level top for memory path bring-up
 *   reset controller, GPIO pad bank,
 *   self-test AXI4 master and SRAM model
 */
`timescale 1ns/100ps

module asic_top (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_pll_locked,
  inout  asic_pkg::gpio_t io_gpio
);

  logic                sys_rst_n;
  logic [3:0]          dip;
  logic [7:0]          led;
  asic_pkg::axi4_req_t mem_req;
  asic_pkg::axi4_rsp_t mem_rsp;

  sys_reset_ctrl u_rst (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_pll_locked (i_pll_locked),
    .o_sys_rst_n  (sys_rst_n)
  );

  gpio_pad_bank u_gpio (
    .i_clk   (i_clk),
    .i_rst_n (sys_rst_n),
    .io_gpio (io_gpio),
    .i_led   (led),
    .o_dip   (dip)
  );

  // Stands in for the SoC on the memory port
  mem_selftest u_bist (
    .i_clk   (i_clk),
    .i_rst_n (sys_rst_n),
    .i_dip   (dip),
    .o_led   (led),
    .o_axi   (mem_req),
    .i_axi   (mem_rsp)
  );

  // DDR functional model, same clock as the system
  axi4_sram u_ddr (
    .i_clk   (i_clk),
    .i_rst_n (sys_rst_n),
    .i_axi   (mem_req),
    .o_axi   (mem_rsp)
  );

endmodule

// File: test/tb_asic_top.sv
/*
 * Directed testbench for the memory bring-up top
 *   clock and reset generation, DIP pad drivers, LED readback
 *   reference model of the self-test patterns and error count
 *   reset, pattern, out-of-range and lock-loss tests
 */
`timescale 1ns/100ps
`include "asic_config.svh"

module tb_asic_top;

  localparam int SRAM_WORDS = 1 << `ASIC_SRAM_ABITS;

  logic       clk;
  logic       rst_n;
  logic       pll_locked;
  logic       dip_en;
  logic [3:0] dip_drv;
  wire  [11:0] gpio;
  logic [7:0] led;
  int         seed;

  // Switches on the low pads, LEDs read back from the high pads
  assign gpio[3:0] = dip_en ? dip_drv : 4'bzzzz;
  assign led       = gpio[11:4];

  asic_top i_dut (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_pll_locked (pll_locked),
    .io_gpio      (gpio)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("CHECK FAILED at %0t: %s is %0h, expected %0h",
                               $time, name, actual, expected));
    end
  endtask

  // Word written at index i of a run
  function automatic logic [31:0] pattern_word(input asic_pkg::pattern_kind_t kind,
                                               input logic [31:0] base, input int i);
    logic [31:0] addr;
    addr = base + 32'(4 * i);
    case (kind)
      asic_pkg::ADDR_XOR: return (addr >> 2) ^ `ASIC_TEST_SEED;
      asic_pkg::ZEROS:    return 32'h0;
      asic_pkg::ONES:     return 32'hffff_ffff;
      default:            return 32'h1 << (i % 32);
    endcase
  endfunction

  // Saturated error count of one run
  function automatic int expected_errors(input logic out_base);
    logic [31:0] base;
    logic [31:0] addr;
    int          cnt;
    base = out_base ? `ASIC_OUT_BASE : 32'h0;
    cnt  = 0;
    for (int i = 0; i < `ASIC_TEST_WORDS; i++) begin
      addr = base + 32'(4 * i);
      // Write and read of a word beyond the SRAM both answer SLVERR
      if (addr >= 32'(4 * SRAM_WORDS)) begin
        cnt = cnt + 2;
      end
    end
    return (cnt > 15) ? 15 : cnt;
  endfunction

  // SRAM contents left behind by a run from base 0
  task automatic check_sram(input asic_pkg::pattern_kind_t kind);
    for (int i = 0; i < `ASIC_TEST_WORDS; i++) begin
      check_val($sformatf("mem[%0d]", i), i_dut.u_ddr.mem[i], pattern_word(kind, 32'h0, i));
    end
  endtask

  task automatic wait_led(input int bit_i, input logic val, input int limit,
                          input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (led[bit_i] !== val) begin
      n++;
      if (n >= limit) report_failure(what);
      else @(negedge clk);
    end
  endtask

  task automatic start_run(input asic_pkg::pattern_kind_t kind, input logic out_base);
    @(posedge clk);
    dip_drv <= {out_base, kind, 1'b0};
    repeat (4) @(posedge clk);
    dip_drv[0] <= 1'b1;
  endtask

  task automatic run_and_check(input asic_pkg::pattern_kind_t kind, input logic out_base);
    int exp_cnt;
    exp_cnt = expected_errors(out_base);
    start_run(kind, out_base);
    wait_led(1, 1'b0, 10, "new start did not clear the done LED");
    wait_led(1, 1'b1, 2000, "timeout waiting for test done");
    check_val("led_busy", led[0], 1'b0);
    check_val("led_pass", led[2], exp_cnt == 0);
    check_val("led_fail", led[3], exp_cnt != 0);
    check_val("led_err_cnt", led[7:4], exp_cnt);
    if (!out_base) begin
      check_sram(kind);
    end
  endtask

  task automatic idle_after_reset();
    repeat (`ASIC_RST_HOLD + 4) @(posedge clk);
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      check_val("led", led, 8'h00);
    end
  endtask

  task automatic addr_xor_run();
    run_and_check(asic_pkg::ADDR_XOR, 1'b0);
    check_val("led_pass", led[2], 1'b1);
  endtask

  task automatic pattern_mix_runs();
    asic_pkg::pattern_kind_t order [3];
    asic_pkg::pattern_kind_t tmp;
    int j;
    order[0] = asic_pkg::ZEROS;
    order[1] = asic_pkg::ONES;
    order[2] = asic_pkg::WALK_ONE;
    // Shuffle so each seed gives a different back-to-back order
    for (int i = 2; i > 0; i--) begin
      j        = $unsigned($random(seed)) % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < 3; i++) begin
      run_and_check(order[i], 1'b0);
      check_val("led_pass", led[2], 1'b1);
    end
  endtask

  task automatic out_of_range_run();
    run_and_check(asic_pkg::ADDR_XOR, 1'b1);
    check_val("led_fail", led[3], 1'b1);
    check_val("led_err_cnt", led[7:4], 4'hf);
  endtask

  task automatic lock_loss_recovery();
    int n;
    start_run(asic_pkg::ADDR_XOR, 1'b0);
    wait_led(0, 1'b1, 10, "self-test never went busy");
    repeat (5) @(posedge clk);
    pll_locked <= 1'b0;
    // Lock loss reaches the system reset, then the engine
    n = 0;
    @(negedge clk);
    while (led !== 8'h00) begin
      n++;
      if (n >= 3) report_failure("LEDs not cleared within the reset latency");
      else @(negedge clk);
    end
    @(posedge clk);
    dip_drv[0] <= 1'b0;
    repeat (4) @(posedge clk);
    pll_locked <= 1'b1;
    repeat (`ASIC_RST_HOLD + 4) @(posedge clk);
    @(negedge clk);
    check_val("led", led, 8'h00);
    run_and_check(asic_pkg::ADDR_XOR, 1'b0);
    check_val("led_pass", led[2], 1'b1);
  endtask

  initial begin
    seed       = 32'h30db_c074;
    rst_n      = 1'b0;
    pll_locked = 1'b1;
    dip_en     = 1'b1;
    dip_drv    = 4'h0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    idle_after_reset();
    addr_xor_run();
    pattern_mix_runs();
    out_of_range_run();
    lock_loss_recovery();

    $display("TB PASSED");
    $finish;
  end

endmodule

// File: tb.f
+incdir+design
design/asic_pkg.sv
design/sys_reset_ctrl.sv
design/gpio_pad_bank.sv
design/mem_selftest.sv
design/axi4_sram.sv
design/asic_top.sv
test/tb_asic_top.sv
